/* ps2_proto_pkg.sv */
package ps2_proto_pkg;

  localparam int frame_bits  = 42;  // receive shift register width
  localparam int ack_end_pos = 21;  // marker position once echo and ack byte are in
  localparam int init_len    = 7;   // commands sent before reports are used

  // command byte with its odd parity bit on top
  localparam logic [8:0] init_cmd_table [init_len] = '{
    9'h0F4,          // enable data reporting
    9'h1F3, 9'h0C8,  // sample rate 200
    9'h1F3, 9'h064,  // sample rate 100
    9'h1F3, 9'h150   // sample rate 80, wheel id unlocked after this one
  };

  // movement report, 41 line samples above the marker
  // first sample (start bit of byte 1) sits at bit 1
  typedef struct packed {
    logic [2:0] wheel_hi;  // 41:39 upper wheel bits, never complete
    logic [3:0] wheel;     // 38:35 signed wheel step
    logic       start4;    // 34
    logic [1:0] tail3;     // 33:32 stop and parity of byte 3
    logic [7:0] y_byte;    // 31:24
    logic [2:0] tail2;     // 23:21 start 3, stop and parity of byte 2
    logic [7:0] x_byte;    // 20:13
    logic [2:0] tail1;     // 12:10 start 2, stop and parity of byte 1
    logic       y_ovf;     // 9
    logic       x_ovf;     // 8
    logic       y_sign;    // 7
    logic       x_sign;    // 6
    logic       sync;      // 5 always one in byte 1
    logic [2:0] btn;       // 4:2 middle, right, left
    logic       start1;    // 1
    logic       mark;      // 0 marker when a report is complete
  } report_view_t;

  // host command seen on the line, device ack bit, then the ack byte
  typedef struct packed {
    logic [7:0]             ack;       // 41:34 normally FA
    logic [1:0]             ack_lead;  // 33:32 start of ack byte, ack bit
    logic [8:0]             echo_cmd;  // 31:23 command and parity as sent
    logic                   start_h;   // 22 host start bit
    logic                   mark;      // 21 marker when an exchange is complete
    logic [ack_end_pos-1:0] fill;      // still zero from the reload
  } ack_view_t;

  typedef union packed {
    report_view_t report;
    ack_view_t    ack;
  } frame_u;

endpackage

/* mouse_pos_pkg.sv */
package mouse_pos_pkg;

  // default counter widths for the top level
  localparam int def_x_bits = 11;
  localparam int def_y_bits = 11;
  localparam int def_z_bits = 11;

  // one movement report after overflow handling
  typedef struct packed {
    logic [2:0]        btn;  // {middle, right, left}
    logic [8:0]        dx;   // two's complement, magnitude zeroed on overflow
    logic [8:0]        dy;   // positive is up on the mouse
    logic signed [3:0] dz;   // wheel step
  } report_t;

endpackage

/* ps2_frame_if.sv */
`timescale 1ns/1ps

interface ps2_frame_if;

  ps2_proto_pkg::frame_u frame;  // receive register, both views
  logic                  done;   // one cycle, frame complete and line idle
  logic [8:0]            cmd;    // next command with parity
  logic                  run;    // init finished, reports are live

  // link layer
  modport phy (
    output frame,
    output done,
    input  cmd,
    input  run
  );

  // init sequencer
  modport seq (
    input  done,
    output cmd,
    output run
  );

  // report consumers
  modport user (
    input frame,
    input done,
    input run
  );

endinterface

/* ps2_line_phy.sv */
`timescale 1ns/1ps

module ps2_line_phy #(
  parameter int count_bits = 15  // idle counter, 15 bits at 25 MHz
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     ms_clk,      // sampled clock line
  input  logic     ms_dat,      // sampled data line
  output logic     ms_clk_low,  // pull clock line low
  output logic     ms_dat_low,  // pull data line low
  ps2_frame_if.phy link
);

  localparam int fb = ps2_proto_pkg::frame_bits;

  // marker at the top, zeros below it
  localparam logic [fb-1:0] rx_empty = {1'b1, {(fb-1){1'b0}}};

  logic [5:0]            filter;    // last six clock line samples
  logic [count_bits-1:0] count;     // idle timer
  logic                  req;       // holding the clock line for a request
  logic [9:0]            tx;        // parity, data, start; bit 0 on the line
  ps2_proto_pkg::frame_u rx;        // line samples enter at the top
  logic                  shift;     // filtered falling edge
  logic                  endcount;  // line has been quiet long enough
  logic                  endbit;    // marker reached its end position

  // one high sample then five low ones
  assign shift    = ~req & (filter == 6'b100000);
  assign endcount = &count[count_bits-1 -: 3];  // top three bits set

  // the two views put the end position at different places
  assign endbit = link.run ? rx.report.mark : rx.ack.mark;

  assign link.done  = endbit & endcount & ~req;
  assign link.frame = rx;

  assign ms_clk_low = req;
  assign ms_dat_low = ~tx[0];  // start bit and zero data bits

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      filter <= '1;  // idle line is high
      count  <= '0;
    end else begin
      filter <= {filter[4:0], ms_clk};
      count  <= (shift || endcount) ? '0 : count + 1'b1;  // restart on every edge
    end
  end

  // request toggles once per idle period until init is over
  // no new request in the cycle a frame completes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req <= 1'b0;
    end else if (link.run) begin
      req <= 1'b0;
    end else if (endcount && !link.done) begin
      req <= ~req;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx <= '1;
    end else if (link.run) begin
      tx <= '1;                       // line released for good
    end else if (req) begin
      tx <= {link.cmd, 1'b0};         // start bit first
    end else if (shift) begin
      tx <= {1'b1, tx[9:1]};          // ones fill behind, ends released
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx <= rx_empty;
    end else if (link.done) begin
      rx <= rx_empty;                 // frame used this cycle
    end else if (shift && !endbit) begin
      rx <= {ms_dat, rx[fb-1:1]};     // extra edges after the end are dropped
    end
  end

  // data only goes low once the start bit was loaded under a request
  assert property (@(posedge clk) disable iff (!arst_n)
    (ms_clk_low && ms_dat_low) |-> $past(req));

  // a frame never completes while a command is still going out
  assert property (@(posedge clk) disable iff (!arst_n)
    link.done |-> (&tx));

endmodule

/* ps2_init_seq.sv */
`timescale 1ns/1ps

module ps2_init_seq (
  input  logic     clk,
  input  logic     arst_n,
  ps2_frame_if.seq link
);

  localparam logic [2:0] last = 3'(ps2_proto_pkg::init_len);

  logic [2:0] sent;  // completed exchanges
  logic       run;

  assign run      = (sent == last);
  assign link.run = run;

  // table index is only valid before the last exchange
  assign link.cmd = run ? 9'h1FF : ps2_proto_pkg::init_cmd_table[sent];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sent <= '0;
    end else if (link.done && !run) begin
      sent <= sent + 3'd1;  // advances on the done edge itself
    end
  end

  // exchanges count up one at a time and stop at the table end
  assert property (@(posedge clk) disable iff (!arst_n)
    (sent != $past(sent)) |-> ($past(sent) < last && sent == $past(sent) + 3'd1));

endmodule

/* mouse_pos_accum.sv */
`timescale 1ns/1ps

module mouse_pos_accum #(
  parameter int x_bits = 11,  // at least 9
  parameter int y_bits = 11,  // at least 9
  parameter int z_bits = 11   // at least 4
) (
  input  logic              clk,
  input  logic              arst_n,
  ps2_frame_if.user         link,
  output logic [x_bits-1:0] x,
  output logic [y_bits-1:0] y,
  output logic [z_bits-1:0] z,
  output logic [2:0]        btn
);

  if (x_bits < 9 || y_bits < 9) begin : g_xy_width
    $error("x_bits and y_bits must be at least 9");
  end

  if (z_bits < 4) begin : g_z_width
    $error("z_bits must be at least 4");
  end

  ps2_proto_pkg::report_view_t rv;   // report view of the receive word
  mouse_pos_pkg::report_t      rpt;  // decoded step
  logic [x_bits-1:0]           dx_ext;
  logic [y_bits-1:0]           dy_ext;
  logic [z_bits-1:0]           dz_ext;

  assign rv = link.frame.report;

  // overflow drops the magnitude, sign stays
  always_comb begin
    rpt.btn = rv.btn;
    rpt.dx  = {rv.x_sign, rv.x_ovf ? 8'h00 : rv.x_byte};
    rpt.dy  = {rv.y_sign, rv.y_ovf ? 8'h00 : rv.y_byte};
    rpt.dz  = rv.wheel;
  end

  // sign extension to counter width
  assign dx_ext = x_bits'($signed(rpt.dx));
  assign dy_ext = y_bits'($signed(rpt.dy));
  assign dz_ext = z_bits'($signed(rpt.dz));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x   <= '0;
      y   <= '0;
      z   <= '0;
      btn <= '0;
    end else if (!link.run) begin
      x   <= '0;  // init replies are not reports
      y   <= '0;
      z   <= '0;
      btn <= '0;
    end else if (link.done) begin
      x   <= x + dx_ext;  // wraps at counter width
      y   <= y - dy_ext;  // screen y grows downwards
      z   <= z + dz_ext;
      btn <= rpt.btn;
    end
  end

  // outputs are still clear whenever run is low, so run never drops back
  assert property (@(posedge clk) disable iff (!arst_n)
    !link.run |-> (x == '0 && y == '0 && z == '0 && btn == '0));

endmodule

/* ps2_mouse_top.sv */
`timescale 1ns/1ps

module ps2_mouse_top #(
  parameter int x_bits     = mouse_pos_pkg::def_x_bits,
  parameter int y_bits     = mouse_pos_pkg::def_y_bits,
  parameter int z_bits     = mouse_pos_pkg::def_z_bits,
  parameter int count_bits = 15  // idle timer width, 15 bits at 25 MHz
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ms_clk,      // clock line as seen at the pin
  input  logic              ms_dat,      // data line as seen at the pin
  output logic              ms_clk_low,  // open drain enable, clock
  output logic              ms_dat_low,  // open drain enable, data
  output logic [x_bits-1:0] x,
  output logic [y_bits-1:0] y,
  output logic [z_bits-1:0] z,
  output logic [2:0]        btn,         // {middle, right, left}
  output logic              ready        // wheel mode set up
);

  ps2_frame_if link ();

  ps2_line_phy #(
    .count_bits (count_bits)
  ) u_phy (
    .clk        (clk),
    .arst_n     (arst_n),
    .ms_clk     (ms_clk),
    .ms_dat     (ms_dat),
    .ms_clk_low (ms_clk_low),
    .ms_dat_low (ms_dat_low),
    .link       (link.phy)
  );

  ps2_init_seq u_seq (
    .clk    (clk),
    .arst_n (arst_n),
    .link   (link.seq)
  );

  mouse_pos_accum #(
    .x_bits (x_bits),
    .y_bits (y_bits),
    .z_bits (z_bits)
  ) u_accum (
    .clk    (clk),
    .arst_n (arst_n),
    .link   (link.user),
    .x      (x),
    .y      (y),
    .z      (z),
    .btn    (btn)
  );

  assign ready = link.run;

endmodule

/* tb_ps2_checker.sv */
`timescale 1ns/1ps

module tb_ps2_checker #(
  parameter int x_bits    = 11,
  parameter int y_bits    = 11,
  parameter int z_bits    = 11,
  parameter int n_cmds    = 7
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ms_clk_low,
  input  logic              ms_dat_low,
  input  logic [x_bits-1:0] x,
  input  logic [y_bits-1:0] y,
  input  logic [z_bits-1:0] z,
  input  logic [2:0]        btn,
  input  logic              ready,
  input  logic              cmd_strobe,  // device has clocked in a command
  input  logic [10:0]       cmd_bits,    // stop, parity, data, start
  input  logic              rpt_strobe,  // report sent and host idle time passed
  input  logic [31:0]       rpt_bytes,
  input  logic              end_strobe,
  output int                value_errors,
  output int                other_errors
);

  // wheel mode knock sequence
  localparam logic [7:0] expected_cmds [7] = '{
    8'hF4, 8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50
  };

  logic [x_bits-1:0] x_m;  // reference position
  logic [y_bits-1:0] y_m;
  logic [z_bits-1:0] z_m;
  logic [2:0]        btn_m;
  int                cmds_seen;
  int                requests;   // clock line pulls by the host
  logic              ready_q;
  logic              clk_low_q;

  initial begin
    value_errors = 0;
    other_errors = 0;
    x_m          = '0;
    y_m          = '0;
    z_m          = '0;
    btn_m        = '0;
    cmds_seen    = 0;
    requests     = 0;
    ready_q      = 1'b0;
    clk_low_q    = 1'b0;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED t=%0t %s: got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic fail(input string what);
    other_errors++;
    $display("error at t=%0t: %s", $time, what);
  endtask

  // overflow keeps only the sign, so the step is 0 or -256
  function automatic int byte_step(input logic sign, input logic ovf, input logic [7:0] mag);
    int v;
    v = ovf ? 0 : int'(mag);
    if (sign) v = v - 256;
    return v;
  endfunction

  always @(posedge clk) begin : watch
    int         dx;
    int         dy;
    int         dz;
    logic [7:0] b1;
    logic [7:0] exp;
    if (arst_n) begin
      if (!ready) begin  // nothing moves during init
        compare("x", 32'(x), 32'd0);
        compare("y", 32'(y), 32'd0);
        compare("z", 32'(z), 32'd0);
        compare("btn", 32'(btn), 32'd0);
      end
      if (ready && !ready_q && cmds_seen != n_cmds)
        fail($sformatf("ready rose after %0d commands instead of %0d", cmds_seen, n_cmds));
      if (ready && (ms_clk_low || ms_dat_low))
        fail("host pulled a bus line after ready");
      if (ms_clk_low && !clk_low_q)
        requests++;

      if (cmd_strobe) begin
        exp = expected_cmds[cmds_seen];
        compare("cmd start", 32'(cmd_bits[0]), 32'd0);
        compare("cmd data", 32'(cmd_bits[8:1]), 32'(exp));
        compare("cmd parity", 32'(cmd_bits[9]), 32'(~^exp));
        compare("cmd stop", 32'(cmd_bits[10]), 32'd1);
        cmds_seen++;
      end

      if (rpt_strobe) begin
        b1 = rpt_bytes[7:0];  // yo xo ys xs 1 m r l
        dx = byte_step(b1[4], b1[6], rpt_bytes[15:8]);
        dy = byte_step(b1[5], b1[7], rpt_bytes[23:16]);
        dz = int'(rpt_bytes[27:24]);
        if (rpt_bytes[27]) dz = dz - 16;  // signed wheel nibble
        x_m   = x_m + x_bits'(dx);
        y_m   = y_m - y_bits'(dy);  // mouse up is screen up
        z_m   = z_m + z_bits'(dz);
        btn_m = b1[2:0];
        if (!ready) fail("ready low while reports are sent");
        compare("x", 32'(x), 32'(x_m));
        compare("y", 32'(y), 32'(y_m));
        compare("z", 32'(z), 32'(z_m));
        compare("btn", 32'(btn), 32'(btn_m));
      end

      if (end_strobe) begin
        if (requests != n_cmds)
          fail($sformatf("host made %0d bus requests, expected %0d", requests, n_cmds));
      end
      ready_q   = ready;
      clk_low_q = ms_clk_low;
    end
  end

endmodule

/* tb_ps2_mouse.sv */
`timescale 1ns/1ps

module tb_ps2_mouse;

  localparam int x_bits     = 11;
  localparam int y_bits     = 11;
  localparam int z_bits     = 11;
  localparam int count_bits = 10;    // idle period about 900 clocks
  localparam int n_cmds     = 7;
  localparam int n_reports  = 40;
  localparam int bit_clks   = 40;    // device clock period in system clocks
  localparam int gap_clks   = 1200;  // quiet time between device frames
  localparam longint limit_ns = longint'(48 * 44 * bit_clks * 2) * 10;

  logic              clk;
  logic              arst_n;
  logic              ms_clk_low;   // host pulls clock line
  logic              ms_dat_low;   // host pulls data line
  logic              dev_clk_low;  // device pulls clock line
  logic              dev_dat_low;  // device pulls data line
  wire               ms_clk;
  wire               ms_dat;
  logic [x_bits-1:0] x;
  logic [y_bits-1:0] y;
  logic [z_bits-1:0] z;
  logic [2:0]        btn;
  logic              ready;

  // handoff from the device model to the checker
  logic              cmd_strobe;
  logic [10:0]       cmd_bits;
  logic              rpt_strobe;
  logic [31:0]       rpt_bytes;
  logic              end_strobe;
  int                value_errors;
  int                other_errors;
  logic [31:0]       rng;  // xorshift state

  // open drain lines with pull-ups
  assign ms_clk = ~(ms_clk_low | dev_clk_low);
  assign ms_dat = ~(ms_dat_low | dev_dat_low);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ps2_mouse_top #(
    .x_bits     (x_bits),
    .y_bits     (y_bits),
    .z_bits     (z_bits),
    .count_bits (count_bits)
  ) u_ps2_mouse_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .ms_clk     (ms_clk),
    .ms_dat     (ms_dat),
    .ms_clk_low (ms_clk_low),
    .ms_dat_low (ms_dat_low),
    .x          (x),
    .y          (y),
    .z          (z),
    .btn        (btn),
    .ready      (ready)
  );

  tb_ps2_checker #(
    .x_bits    (x_bits),
    .y_bits    (y_bits),
    .z_bits    (z_bits),
    .n_cmds    (n_cmds)
  ) u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .ms_clk_low   (ms_clk_low),
    .ms_dat_low   (ms_dat_low),
    .x            (x),
    .y            (y),
    .z            (z),
    .btn          (btn),
    .ready        (ready),
    .cmd_strobe   (cmd_strobe),
    .cmd_bits     (cmd_bits),
    .rpt_strobe   (rpt_strobe),
    .rpt_bytes    (rpt_bytes),
    .end_strobe   (end_strobe),
    .value_errors (value_errors),
    .other_errors (other_errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // byte 1 in the low byte, wheel byte on top
  function automatic logic [31:0] make_report(input logic [31:0] r);
    logic [7:0] b1;
    b1 = {r[10:8] == 3'd0, r[7:5] == 3'd0, r[4], r[3], 1'b1, r[2:0]};  // ovf one in eight
    return {{4{r[30]}}, r[30:27], r[26:19], r[18:11], b1};
  endfunction

  // one device clock, low then high, line sampled mid low phase
  task automatic clock_pulse(output logic sample);
    dev_clk_low = 1'b1;
    repeat (15) @(negedge clk);
    sample = ms_dat;
    repeat (5) @(negedge clk);
    dev_clk_low = 1'b0;
    repeat (bit_clks - 25) @(negedge clk);
  endtask

  task automatic send_bit(input logic b);
    logic unused;
    dev_dat_low = ~b;
    repeat (5) @(negedge clk);  // data settles before the fall
    clock_pulse(unused);
  endtask

  task automatic send_byte(input logic [7:0] d);
    send_bit(1'b0);  // start
    for (int i = 0; i < 8; i++) begin
      send_bit(d[i]);  // lsb first
    end
    send_bit(~^d);  // odd parity
    send_bit(1'b1);  // stop, line released
  endtask

  // waits for a host request, then clocks in start, data, parity, stop
  task automatic take_command(output logic [10:0] bits);
    logic b;
    @(negedge clk);
    while (ms_clk_low || !ms_dat_low) @(negedge clk);  // clock released, data held low
    repeat (50) @(negedge clk);
    bits[0] = ms_dat;
    for (int k = 1; k <= 10; k++) begin
      repeat (5) @(negedge clk);
      clock_pulse(b);
      bits[k] = b;
    end
    send_bit(1'b0);  // ack bit
    dev_dat_low = 1'b0;
  endtask

  // device model, all lines change on the falling system clock
  initial begin
    logic [10:0] bits;
    logic [31:0] rpt;
    arst_n      = 1'b0;
    dev_clk_low = 1'b0;
    dev_dat_low = 1'b0;
    cmd_strobe  = 1'b0;
    cmd_bits    = '0;
    rpt_strobe  = 1'b0;
    rpt_bytes   = '0;
    end_strobe  = 1'b0;
    rng         = 32'h5521_4179;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    for (int n = 0; n < n_cmds; n++) begin
      take_command(bits);
      cmd_bits   = bits;
      cmd_strobe = 1'b1;
      @(negedge clk);
      cmd_strobe = 1'b0;
      send_byte(8'hFA);  // acknowledge
    end

    while (!ready) @(negedge clk);
    repeat (gap_clks) @(negedge clk);

    for (int n = 0; n < n_reports; n++) begin
      rng = xorshift(rng);
      rpt = make_report(rng);
      for (int b = 0; b < 4; b++) begin
        send_byte(rpt[8*b +: 8]);
      end
      repeat (gap_clks) @(negedge clk);  // host accepts after one idle period
      rpt_bytes  = rpt;
      rpt_strobe = 1'b1;
      @(negedge clk);
      rpt_strobe = 1'b0;
    end

    end_strobe = 1'b1;
    @(negedge clk);
    end_strobe = 1'b0;
    @(negedge clk);
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, twice the time of 48 frames of 44 bits
  initial begin
    #(limit_ns);
    $display("watchdog expired before the device model finished");
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* all.f */
ps2_proto_pkg.sv
mouse_pos_pkg.sv
ps2_frame_if.sv
ps2_line_phy.sv
ps2_init_seq.sv
mouse_pos_accum.sv
ps2_mouse_top.sv
tb_ps2_checker.sv
tb_ps2_mouse.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ps2_mouse
RTL_TOP   ?= ps2_mouse_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
